// ==== Makefile ====
SRCS = psgPkg.sv psgBusArbiter.sv psgFetchUnit.sv psgSlotBank.sv psgMixer.sv \
	psgWaveSubsystem.sv tbClockGen.sv tbPsgWave.sv

.PHONY: run clean

run: obj_dir/VtbPsgWave
	./obj_dir/VtbPsgWave | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

obj_dir/VtbPsgWave: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tbPsgWave -f files.f

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
psgPkg.sv
psgBusArbiter.sv
psgFetchUnit.sv
psgSlotBank.sv
psgMixer.sv
psgWaveSubsystem.sv
tbClockGen.sv
tbPsgWave.sv

// ==== psgBusArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module psgBusArbiter (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic ce,
	input  wire logic ack,
	input  wire logic [psgPkg::NUM_CHANNELS-1:0] req,
	output logic [psgPkg::NUM_CHANNELS-1:0] sel,
	output logic [psgPkg::CHAN_W-1:0] seln
);

	logic [psgPkg::NUM_CHANNELS-1:0] lowReq;
	logic [psgPkg::CHAN_W-1:0] lowIdx;

	// lowest set request bit, channel 0 wins
	assign lowReq = req & (~req + 1'b1);

	always_comb begin
		lowIdx = '0;
		for (int i = psgPkg::NUM_CHANNELS - 1; i >= 0; i--) begin
			if (req[i]) begin
				lowIdx = i[psgPkg::CHAN_W-1:0];
			end
		end
	end

	// ==================================================
	// owner register
	// ==================================================
	// re-arbitrate only on an enabled acknowledge
	// with no request pending the last owner keeps the bus
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && ack && (|req)) begin
			sel <= lowReq;
			seln <= lowIdx;
		end
	end

	// ==================================================
	// checks
	// ==================================================
	aSelOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(sel));

	// owner code agrees with the select vector
	aSelCode: assert property (@(posedge clk) disable iff (rst)
		(sel != '0) |-> sel[seln]);

	// no movement without an enabled acknowledge
	aGrantHold: assert property (@(posedge clk) disable iff (rst)
		!(ce && ack) |=> ($stable(sel) && $stable(seln)));

	// nothing below the new owner may have been requesting
	aPriority: assert property (@(posedge clk) disable iff (rst)
		(ce && ack && (|req)) |=>
			((sel != '0) && (($past(req) & (sel - 1'b1)) == '0)));

endmodule

`default_nettype wire

// ==== psgFetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module psgFetchUnit (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic cfgWr,
	input  wire psgPkg::chanCfg_t cfg,
	input  wire logic [psgPkg::NUM_CHANNELS-1:0] full,
	input  wire logic [psgPkg::NUM_CHANNELS-1:0] sel,
	input  wire logic [psgPkg::CHAN_W-1:0] seln,
	input  wire logic ce,
	input  wire logic ack,
	input  wire logic signed [psgPkg::SAMPLE_W-1:0] busData,
	output logic busReq,
	output logic [psgPkg::ADDR_W-1:0] busAddr,
	output logic [psgPkg::CHAN_W-1:0] busChan,
	output logic [psgPkg::NUM_CHANNELS-1:0] req,
	output logic arbAck,
	output logic fetchWr,
	output psgPkg::fetchDone_t fetchDone
);

	psgPkg::fetchState_t state;
	logic [psgPkg::NUM_CHANNELS-1:0] chanEnable;
	logic [psgPkg::ADDR_W-1:0] chanBase [psgPkg::NUM_CHANNELS];
	logic [psgPkg::LEN_W-1:0] chanLen [psgPkg::NUM_CHANNELS];
	logic [psgPkg::LEN_W-1:0] chanPtr [psgPkg::NUM_CHANNELS];
	logic [psgPkg::NUM_CHANNELS-1:0] doneMask;
	logic [psgPkg::LEN_W-1:0] nextPtr;
	logic done;
	logic grantHit;

	assign busReq = (state == psgPkg::fsTransfer);
	assign done = busReq && ce && ack;
	// a stale owner waits while a lower channel requests
	assign grantHit = |(sel & req) && ((req & (sel - 1'b1)) == '0);

	// finishing channel drops out so it is not granted again at once
	always_comb begin
		doneMask = '0;
		if (done) begin
			doneMask[busChan] = 1'b1;
		end
	end

	assign req = chanEnable & ~full & ~doneMask;

	// arbiter freezes once a grant has been taken
	assign arbAck = busReq ? (ce && ack) : (ce && !grantHit);

	// 8-bit wrap covers the len of 0 case
	always_comb begin
		nextPtr = chanPtr[busChan] + 1'b1;
		if (nextPtr == chanLen[busChan]) begin
			nextPtr = '0;
		end
	end

	// ==================================================
	// channel table
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			chanEnable <= '0;
			for (int i = 0; i < psgPkg::NUM_CHANNELS; i++) begin
				chanPtr[i] <= '0;
			end
		end else begin
			if (done) begin
				chanPtr[busChan] <= nextPtr;
			end
			// a new configuration restarts the table
			if (cfgWr) begin
				chanEnable[cfg.chan] <= cfg.enable;
				chanPtr[cfg.chan] <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfgWr) begin
			chanBase[cfg.chan] <= cfg.baseAddr;
			chanLen[cfg.chan] <= cfg.len;
		end
	end

	// ==================================================
	// bus FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= psgPkg::fsArbitrate;
			busChan <= '0;
		end else begin
			case (state)
				psgPkg::fsArbitrate: begin
					if (grantHit) begin
						state <= psgPkg::fsTransfer;
						busChan <= seln;
					end
				end
				psgPkg::fsTransfer: begin
					if (ce && ack) begin
						state <= psgPkg::fsArbitrate;
					end
				end
				default: state <= psgPkg::fsArbitrate;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!busReq && grantHit) begin
			busAddr <= chanBase[seln] + {{(psgPkg::ADDR_W - psgPkg::LEN_W){1'b0}}, chanPtr[seln]};
		end
	end

	// sample goes straight to the slot bank on the completion cycle
	assign fetchWr = done;
	assign fetchDone.chan = busChan;
	assign fetchDone.sample = busData;

	aAddrHold: assert property (@(posedge clk) disable iff (rst)
		(busReq && !(ce && ack)) |=> (busReq && $stable(busAddr) && $stable(busChan)));

	// bus owner seen by the arbiter matches the channel on the bus
	aOwnerMatch: assert property (@(posedge clk) disable iff (rst)
		busReq |-> (seln == busChan));

endmodule

`default_nettype wire

// ==== psgMixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module psgMixer (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic sampleTick,
	input  wire logic [psgPkg::NUM_CHANNELS-1:0] full,
	input  wire logic signed [psgPkg::SAMPLE_W-1:0] slot [psgPkg::NUM_CHANNELS],
	output logic [psgPkg::NUM_CHANNELS-1:0] drainMask,
	output logic mixValid,
	output psgPkg::mixOut_t mix
);

	logic signed [psgPkg::MIX_W-1:0] tickSum;

	// empty slots add nothing
	always_comb begin
		tickSum = '0;
		for (int i = 0; i < psgPkg::NUM_CHANNELS; i++) begin
			if (full[i]) begin
				tickSum = tickSum + {{(psgPkg::MIX_W - psgPkg::SAMPLE_W){slot[i][psgPkg::SAMPLE_W-1]}},
					slot[i]};
			end
		end
	end

	// take exactly the slots that were summed
	assign drainMask = full & {psgPkg::NUM_CHANNELS{sampleTick}};

	always_ff @(posedge clk) begin
		if (rst) begin
			mixValid <= 1'b0;
		end else begin
			mixValid <= sampleTick;
		end
	end

	always_ff @(posedge clk) begin
		if (sampleTick) begin
			mix.sum <= tickSum;
		end
	end

	// a drained slot is empty afterwards, no refill can race it
	aDrainClears: assert property (@(posedge clk) disable iff (rst)
		(|drainMask) |=> ((full & $past(drainMask)) == '0));

endmodule

`default_nettype wire

// ==== psgPkg.sv ====
`default_nettype none

package psgPkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int NUM_CHANNELS = 8;
	// owner code width, fixed by the eight channels
	localparam int CHAN_W = 3;
	localparam int ADDR_W = 16;
	localparam int SAMPLE_W = 12;
	// a length of 0 selects a 256 entry table
	localparam int LEN_W = 8;
	// three bits of headroom over one sample
	localparam int MIX_W = 15;

	// ==================================================
	// records
	// ==================================================
	// channel configuration write
	typedef struct packed {
		logic [CHAN_W-1:0] chan;
		logic enable;
		logic [ADDR_W-1:0] baseAddr;
		logic [LEN_W-1:0] len;
	} chanCfg_t;

	// one completed table fetch
	typedef struct packed {
		logic [CHAN_W-1:0] chan;
		logic signed [SAMPLE_W-1:0] sample;
	} fetchDone_t;

	typedef struct packed {
		logic signed [MIX_W-1:0] sum;
	} mixOut_t;

	typedef enum logic {
		fsArbitrate,
		fsTransfer
	} fetchState_t;

endpackage

`default_nettype wire

// ==== psgSlotBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module psgSlotBank (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic fetchWr,
	input  wire psgPkg::fetchDone_t fetchDone,
	input  wire logic [psgPkg::NUM_CHANNELS-1:0] drainMask,
	output logic [psgPkg::NUM_CHANNELS-1:0] full,
	output logic signed [psgPkg::SAMPLE_W-1:0] slot [psgPkg::NUM_CHANNELS]
);

	// ==================================================
	// full flags
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			full <= '0;
		end else begin
			for (int i = 0; i < psgPkg::NUM_CHANNELS; i++) begin
				// fill beats a drain landing on the same slot
				if (fetchWr && (fetchDone.chan == i[psgPkg::CHAN_W-1:0])) begin
					full[i] <= 1'b1;
				end else if (drainMask[i]) begin
					full[i] <= 1'b0;
				end
			end
		end
	end

	// sample storage
	always_ff @(posedge clk) begin
		if (fetchWr) begin
			slot[fetchDone.chan] <= fetchDone.sample;
		end
	end

	// ==================================================
	// checks
	// ==================================================
	// fetch unit only requests for empty slots
	aFillEmpty: assert property (@(posedge clk) disable iff (rst)
		fetchWr |-> !full[fetchDone.chan]);

endmodule

`default_nettype wire

// ==== psgWaveSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module psgWaveSubsystem (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic ce,
	input  wire logic cfgWr,
	input  wire psgPkg::chanCfg_t cfg,
	output logic busReq,
	output logic [psgPkg::ADDR_W-1:0] busAddr,
	output logic [psgPkg::CHAN_W-1:0] busChan,
	input  wire logic ack,
	input  wire logic signed [psgPkg::SAMPLE_W-1:0] busData,
	input  wire logic sampleTick,
	output logic mixValid,
	output psgPkg::mixOut_t mix
);

	logic [psgPkg::NUM_CHANNELS-1:0] req;
	logic [psgPkg::NUM_CHANNELS-1:0] sel;
	logic [psgPkg::CHAN_W-1:0] seln;
	logic arbAck;
	logic fetchWr;
	psgPkg::fetchDone_t fetchDone;
	logic [psgPkg::NUM_CHANNELS-1:0] full;
	logic [psgPkg::NUM_CHANNELS-1:0] drainMask;
	logic signed [psgPkg::SAMPLE_W-1:0] slot [psgPkg::NUM_CHANNELS];

	// ==================================================
	// bus side
	// ==================================================
	psgBusArbiter i_arbiter (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.ack  (arbAck),
		.req  (req),
		.sel  (sel),
		.seln (seln)
	);

	psgFetchUnit i_fetch (
		.clk       (clk),
		.rst       (rst),
		.cfgWr     (cfgWr),
		.cfg       (cfg),
		.full      (full),
		.sel       (sel),
		.seln      (seln),
		.ce        (ce),
		.ack       (ack),
		.busData   (busData),
		.busReq    (busReq),
		.busAddr   (busAddr),
		.busChan   (busChan),
		.req       (req),
		.arbAck    (arbAck),
		.fetchWr   (fetchWr),
		.fetchDone (fetchDone)
	);

	// ==================================================
	// audio side
	// ==================================================
	psgSlotBank i_slots (
		.clk       (clk),
		.rst       (rst),
		.fetchWr   (fetchWr),
		.fetchDone (fetchDone),
		.drainMask (drainMask),
		.full      (full),
		.slot      (slot)
	);

	psgMixer i_mixer (
		.clk        (clk),
		.rst        (rst),
		.sampleTick (sampleTick),
		.full       (full),
		.slot       (slot),
		.drainMask  (drainMask),
		.mixValid   (mixValid),
		.mix        (mix)
	);

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held over the first eight rising edges
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== tbPsgWave.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbPsgWave;

	logic clk;
	logic rst;
	logic ce;
	logic cfgWr;
	psgPkg::chanCfg_t cfg;
	logic busReq;
	logic [psgPkg::ADDR_W-1:0] busAddr;
	logic [psgPkg::CHAN_W-1:0] busChan;
	logic ack;
	logic signed [psgPkg::SAMPLE_W-1:0] busData;
	logic sampleTick;
	logic mixValid;
	psgPkg::mixOut_t mix;

	// reference model of the channel tables and the mix
	logic [psgPkg::NUM_CHANNELS-1:0] expEnable;
	logic [psgPkg::ADDR_W-1:0] expBase [psgPkg::NUM_CHANNELS];
	logic [psgPkg::LEN_W-1:0] expLen [psgPkg::NUM_CHANNELS];
	logic [psgPkg::LEN_W-1:0] expPtr [psgPkg::NUM_CHANNELS];
	logic [psgPkg::ADDR_W-1:0] expAddr;
	logic [psgPkg::SAMPLE_W-1:0] expData;
	logic signed [psgPkg::MIX_W-1:0] expSample;
	logic signed [psgPkg::MIX_W-1:0] pendSum;
	logic signed [psgPkg::MIX_W-1:0] expMix;
	logic [psgPkg::NUM_CHANNELS-1:0] periodMask;
	logic [psgPkg::CHAN_W-1:0] lastChan;
	logic periodAny;
	logic cfgSeen;
	logic done;

	// memory model state
	integer seed;
	logic [1:0] cePhase;
	logic [1:0] ackDelay;
	logic ackArmed;

	int errCount;
	int doneCount;
	int mixCount;
	int cycleCount;

	tbClockGen i_clockGen (
		.clk (clk),
		.rst (rst)
	);

	psgWaveSubsystem i_dut (
		.clk        (clk),
		.rst        (rst),
		.ce         (ce),
		.cfgWr      (cfgWr),
		.cfg        (cfg),
		.busReq     (busReq),
		.busAddr    (busAddr),
		.busChan    (busChan),
		.ack        (ack),
		.busData    (busData),
		.sampleTick (sampleTick),
		.mixValid   (mixValid),
		.mix        (mix)
	);

	// ==================================================
	// helpers
	// ==================================================
	task automatic logError(input string msg);
		errCount = errCount + 1;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// next table index, a length of 0 is a 256 entry table
	function automatic logic [psgPkg::LEN_W-1:0] stepIndex(
		input logic [psgPkg::LEN_W-1:0] idx,
		input logic [psgPkg::LEN_W-1:0] len
	);
		int tableLen;
		tableLen = (len == 0) ? 256 : int'(len);
		stepIndex = psgPkg::LEN_W'((int'(idx) + 1) % tableLen);
	endfunction

	task automatic stepCycle;
		@(posedge clk);
		#2;
	endtask

	task automatic writeConfig(
		input logic [psgPkg::CHAN_W-1:0] chan,
		input logic [psgPkg::ADDR_W-1:0] base,
		input logic [psgPkg::LEN_W-1:0] len
	);
		cfg.chan = chan;
		cfg.enable = 1'b1;
		cfg.baseAddr = base;
		cfg.len = len;
		cfgWr = 1'b1;
		stepCycle();
		cfgWr = 1'b0;
	endtask

	task automatic runTicks(input int count);
		repeat (count) begin
			repeat (39) stepCycle();
			sampleTick = 1'b1;
			stepCycle();
			sampleTick = 1'b0;
		end
	endtask

	// ==================================================
	// memory model and bus clock enable
	// ==================================================
	always @(posedge clk) begin
		#2;
		cePhase = cePhase + 2'd1;
		// one cycle in four without enable
		ce = (cePhase != 2'd3);
		if (rst || !busReq) begin
			ackArmed = 1'b0;
			ack = 1'b0;
		end else begin
			if (!ackArmed) begin
				ackArmed = 1'b1;
				ackDelay = 2'($unsigned($random(seed)) % 4);
			end
			if (ackDelay == 2'd0) begin
				ack = 1'b1;
			end else begin
				ack = 1'b0;
				ackDelay = ackDelay - 2'd1;
			end
		end
		busData = busAddr[psgPkg::SAMPLE_W-1:0] ^ 12'hA5A;
	end

	// ==================================================
	// reference model
	// ==================================================
	assign done = busReq && ce && ack;
	assign expAddr = expBase[busChan]
		+ {{(psgPkg::ADDR_W - psgPkg::LEN_W){1'b0}}, expPtr[busChan]};
	assign expData = expAddr[psgPkg::SAMPLE_W-1:0] ^ 12'hA5A;
	assign expSample = {{(psgPkg::MIX_W - psgPkg::SAMPLE_W){expData[psgPkg::SAMPLE_W-1]}},
		expData};

	always @(posedge clk) begin
		if (rst) begin
			expEnable <= '0;
			for (int i = 0; i < psgPkg::NUM_CHANNELS; i++) begin
				expPtr[i] <= '0;
			end
			cfgSeen <= 1'b0;
			pendSum <= '0;
			expMix <= '0;
			periodMask <= '0;
			periodAny <= 1'b0;
			lastChan <= '0;
		end else begin
			if (done) begin
				expPtr[busChan] <= stepIndex(expPtr[busChan], expLen[busChan]);
				lastChan <= busChan;
				doneCount <= doneCount + 1;
			end
			if (cfgWr) begin
				cfgSeen <= 1'b1;
				expEnable[cfg.chan] <= cfg.enable;
				expBase[cfg.chan] <= cfg.baseAddr;
				expLen[cfg.chan] <= cfg.len;
				expPtr[cfg.chan] <= '0;
			end
			// a completion on the tick cycle opens the next period
			if (sampleTick) begin
				expMix <= pendSum;
				pendSum <= done ? expSample : '0;
				periodMask <= done ? (8'b1 << busChan) : '0;
				periodAny <= done;
			end else if (done) begin
				pendSum <= pendSum + expSample;
				periodMask[busChan] <= 1'b1;
				periodAny <= 1'b1;
			end
			if (mixValid) begin
				mixCount <= mixCount + 1;
			end
		end
	end

	// ==================================================
	// checks
	// ==================================================
	aQuietStart: assert property (@(posedge clk) disable iff (rst)
		!cfgSeen |-> (!busReq && !mixValid))
		else logError("bus request or mix strobe before any configuration");

	aAddrSeq: assert property (@(posedge clk) disable iff (rst)
		done |-> (busAddr == expAddr))
		else logError("completed transfer address is off the table sequence");

	aHold: assert property (@(posedge clk) disable iff (rst)
		(busReq && !(ce && ack)) |=> (busReq && $stable(busAddr) && $stable(busChan)))
		else logError("bus address or owner moved during a transfer");

	aOrder: assert property (@(posedge clk) disable iff (rst)
		(done && !sampleTick && periodAny) |-> (busChan > lastChan))
		else logError("completions within a tick period out of priority order");

	aOnce: assert property (@(posedge clk) disable iff (rst)
		(done && !sampleTick) |-> !periodMask[busChan])
		else logError("channel completed twice within a tick period");

	aEnabledOnly: assert property (@(posedge clk) disable iff (rst)
		busReq |-> expEnable[busChan])
		else logError("disabled channel owns the bus");

	aMixStrobe: assert property (@(posedge clk) disable iff (rst)
		mixValid == $past(sampleTick))
		else logError("mix strobe not exactly one cycle after the tick");

	aMixSum: assert property (@(posedge clk) disable iff (rst)
		sampleTick |=> (mix.sum == expMix))
		else logError("mix sum differs from the samples fetched in the period");

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		ce = 1'b0;
		ack = 1'b0;
		busData = '0;
		cfgWr = 1'b0;
		cfg = '0;
		sampleTick = 1'b0;
		seed = 70168;
		cePhase = '0;
		ackDelay = '0;
		ackArmed = 1'b0;
		errCount = 0;
		doneCount = 0;
		mixCount = 0;
		wait (!rst);
		repeat (6) stepCycle();

		// channels 3 and 6 stay disabled
		writeConfig(3'd0, 16'h0100, 8'd3);
		writeConfig(3'd1, 16'h0240, 8'd4);
		writeConfig(3'd2, 16'h0380, 8'd5);
		writeConfig(3'd4, 16'h04C0, 8'd2);
		writeConfig(3'd5, 16'h0500, 8'd6);
		writeConfig(3'd7, 16'hFFFE, 8'd4);
		runTicks(29);

		// new base for channel 1 on a tick, when the bus is idle
		repeat (39) stepCycle();
		sampleTick = 1'b1;
		writeConfig(3'd1, 16'h0A00, 8'd5);
		sampleTick = 1'b0;
		runTicks(10);
		repeat (2) stepCycle();

		if (mixCount != 40) begin
			logError($sformatf("saw %0d mix strobes instead of 40", mixCount));
		end
		if (doneCount == 0) begin
			logError("no bus transfer completed");
		end
		$display("summary: %0d errors, %0d transfers, %0d mixes", errCount, doneCount, mixCount);
		if (errCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// about 1650 cycles are needed, so 2500 leaves room
	initial begin
		cycleCount = 0;
		while (cycleCount < 2500) begin
			@(posedge clk);
			cycleCount = cycleCount + 1;
		end
		$display("timeout: the run did not finish within 2500 clock cycles");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
